//--- flist.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/prefetch_queue.sv
hw/instr_align.sv
hw/regnum_predecode.sv
hw/fetch_frontend.sv
tests/fetch_frontend_assert.sv
tests/tb_fetch_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_fetch_frontend -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation stopped with status $status"
	exit 1
fi

//--- tests/fetch_stim.txt
// columns: op (1 hex digit) then argument (8 hex digits)
// op 4 bad word index, 3 addr_rdy pattern, 2 run cycles, 1 jump target, 0 end
400000014
40000002c
40000004a
30000ffff
200000028
1000000b2
200000020
30000b6d5
200000030
100000120
200000028
300005555
1000001a6
200000028
300000f0f
200000028
1000003fe
200000020
30000ffff
100000010
200000018
000000000

//--- tests/tb_fetch_frontend.sv
/*
 * testbench for the fetch front end: clock and reset, memory model
 * with a random image, error words and addr_rdy stalls, reference pc
 * model that drives cir_use, checks on bus, CIR, error bits and predecode
 */

`timescale 1ns/10ps

module tb_fetch_frontend;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0040;
	localparam int          IDLE_LIMIT   = 32;
	localparam int          JUMP_LIMIT   = 16;

	logic        clk;
	logic        rst_n;
	logic [31:0] mem_addr;
	logic        mem_addr_vld;
	logic        mem_addr_rdy;
	logic [31:0] mem_data;
	logic        mem_data_err;
	logic        mem_data_vld;
	logic [31:0] jump_target;
	logic        jump_target_vld;
	logic        jump_target_rdy;
	logic [31:0] cir;
	logic [1:0]  cir_vld;
	logic [1:0]  cir_err;
	logic [1:0]  cir_use;
	logic [4:0]  next_regs_rs1;
	logic [4:0]  next_regs_rs2;

	// memory image, error flags per word and the stimulus program
	logic [31:0] image [0:255];
	logic        bad_word [0:255];
	logic [35:0] stim [0:63];
	logic [31:0] lfsr;
	logic [15:0] rdy_pattern;
	// accepted addresses waiting for their data, with the cycle it returns in
	logic [31:0] resp_addr [$];
	int          resp_due [$];
	int          cyc;
	int          last_due;
	int          idle;
	logic [31:0] ref_pc;
	logic [31:0] exp_fetch;
	logic        held;
	logic [31:0] held_addr;
	logic        expect_flushed;
	logic [4:0]  prev_rs1;
	logic [4:0]  prev_rs2;

	fetch_frontend #(
		.FIFO_DEPTH   (2),
		.RESET_VECTOR (RESET_VECTOR)
	) DUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_err         (cir_err),
		.cir_use         (cir_use),
		.next_regs_rs1   (next_regs_rs1),
		.next_regs_rs2   (next_regs_rs2)
	);

	always #10 clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------

	// Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// one random bit, the register steps once per bit
	function automatic logic take_bit();
		take_bit = lfsr[0];
		lfsr     = lfsr_next(lfsr);
	endfunction

	function automatic logic [15:0] hw_at(input logic [31:0] pc);
		logic [31:0] w;
		w     = image[pc[9:2]];
		hw_at = pc[1] ? w[31:16] : w[15:0];
	endfunction

	// register numbers of an instruction, rs1 in the upper five bits
	function automatic logic [9:0] decode_regs(input logic [31:0] ins);
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		f3  = ins[15:13];
		rs1 = {2'b01, ins[9:7]};
		rs2 = {2'b01, ins[4:2]};
		if (ins[1:0] == 2'b11) begin
			rs1 = ins[19:15];
			rs2 = ins[24:20];
		end else if (ins[1:0] == 2'b00) begin
			if (f3 == 3'b000) begin
				rs1 = 5'd2;
			end
		end else if (ins[1:0] == 2'b01) begin
			if (f3 == 3'b011) begin
				rs1 = 5'd2;
			end else if (f3 == 3'b000) begin
				rs1 = ins[11:7];
			end
		end else begin
			// quadrant 2 names full registers, lwsp and swsp go through sp
			rs2 = ins[6:2];
			rs1 = (f3 == 3'b010 || f3 == 3'b110) ? 5'd2 : ins[11:7];
		end
		decode_regs = {rs1, rs2};
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("** FAIL **");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at %0d ns: %s", $time, why);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	// ------------------------------
	// one clock cycle
	// ------------------------------

	// drives inputs after the edge, samples and checks in mid-cycle
	task automatic run_cycle(input logic jump_req, input logic [31:0] target,
			output logic taken);
		logic [1:0]  len;
		logic [1:0]  use_hw;
		logic [31:0] ins;
		logic [31:0] pc_hi;
		logic [31:0] a;
		int          due;
		@(posedge clk);
		#1;
		cyc++;
		mem_data_vld = 1'b0;
		mem_data     = 32'h0;
		mem_data_err = 1'b0;
		if (resp_due.size() != 0 && resp_due[0] == cyc) begin
			a            = resp_addr.pop_front();
			void'(resp_due.pop_front());
			mem_data_vld = 1'b1;
			mem_data     = image[a[9:2]];
			mem_data_err = bad_word[a[9:2]];
		end
		mem_addr_rdy    = rdy_pattern[cyc[3:0]];
		jump_target_vld = jump_req;
		jump_target     = target;
		if (expect_flushed) begin
			check_eq(32'(cir_vld), 32'd0, "cir_vld after a jump");
		end
		// decode takes the whole instruction at the reference pc, or nothing
		use_hw = 2'd0;
		pc_hi  = ref_pc + 32'd2;
		ins    = {hw_at(pc_hi), hw_at(ref_pc)};
		len    = (ins[1:0] == 2'b11) ? 2'd2 : 2'd1;
		if (!jump_req && cir_vld >= len) begin
			check_eq(32'(cir[15:0]), 32'(ins[15:0]), "cir low halfword");
			check_eq(32'(cir_err[0]), 32'(bad_word[ref_pc[9:2]]), "cir_err[0]");
			if (len == 2'd2) begin
				check_eq(32'(cir[31:16]), 32'(ins[31:16]), "cir high halfword");
				check_eq(32'(cir_err[1]), 32'(bad_word[pc_hi[9:2]]), "cir_err[1]");
			end
			// predecode saw this word one cycle before it entered the CIR
			check_eq(32'({prev_rs1, prev_rs2}), 32'(decode_regs(ins)), "next_regs rs1 and rs2");
			use_hw = len;
		end
		cir_use = use_hw;
		#9;
		if (held) begin
			check_eq(32'(mem_addr_vld), 32'd1, "mem_addr_vld while held");
			check_eq(mem_addr, held_addr, "mem_addr while held");
		end
		// jumps are refused only while an address is held
		check_eq(32'(jump_target_rdy), 32'(!held), "jump_target_rdy");
		taken = jump_req && jump_target_rdy;
		if (taken) begin
			check_eq(32'(mem_addr_vld), 32'd1, "mem_addr_vld in the jump cycle");
			check_eq(mem_addr, {target[31:2], 2'b00}, "mem_addr in the jump cycle");
			exp_fetch = {target[31:2], 2'b00};
		end
		if (mem_addr_vld && mem_addr_rdy) begin
			check_eq(mem_addr, exp_fetch, "accepted mem_addr");
			exp_fetch = exp_fetch + 32'd4;
			// data returns in order, one or two cycles later
			due = cyc + 1 + int'(take_bit());
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			resp_addr.push_back(mem_addr);
			resp_due.push_back(due);
		end
		held      = mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;
		prev_rs1  = next_regs_rs1;
		prev_rs2  = next_regs_rs2;
		if (use_hw != 2'd0) begin
			ref_pc = ref_pc + {29'd0, use_hw, 1'b0};
			idle   = 0;
		end else begin
			idle++;
		end
		if (idle > IDLE_LIMIT) begin
			abort_run("no instruction reached the CIR within the time limit");
		end
		if (taken) begin
			ref_pc = target;
		end
		expect_flushed = taken;
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		logic        taken;
		logic [3:0]  op;
		logic [31:0] arg;
		int          i;
		int          b;
		int          n;
		int          tries;
		clk             = 1'b0;
		rst_n           = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = 32'h0;
		mem_data_err    = 1'b0;
		mem_data_vld    = 1'b0;
		jump_target     = 32'h0;
		jump_target_vld = 1'b0;
		cir_use         = 2'd0;
		rdy_pattern     = 16'hffff;
		cyc             = 0;
		last_due        = 0;
		idle            = 0;
		ref_pc          = RESET_VECTOR;
		exp_fetch       = RESET_VECTOR;
		held            = 1'b0;
		held_addr       = 32'h0;
		expect_flushed  = 1'b0;
		prev_rs1        = 5'd0;
		prev_rs2        = 5'd0;
		lfsr            = 32'hd708_1b68;
		for (i = 0; i < 256; i++) begin
			for (b = 0; b < 32; b++) begin
				image[i][b] = take_bit();
			end
			bad_word[i] = 1'b0;
		end
		for (i = 0; i < 64; i++) begin
			stim[i] = 36'h0;
		end
		$readmemh("tests/fetch_stim.txt", stim);
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// an all-zero line ends the program
		for (i = 0; i < 64 && stim[i][35:32] != 4'h0; i++) begin
			op  = stim[i][35:32];
			arg = stim[i][31:0];
			case (op)
				4'h1: begin
					tries = 0;
					taken = 1'b0;
					while (!taken) begin
						if (tries == JUMP_LIMIT) begin
							abort_run("jump target was never accepted");
						end
						run_cycle(1'b1, arg, taken);
						tries++;
					end
				end
				4'h2: begin
					for (n = 0; n < int'(arg); n++) begin
						run_cycle(1'b0, 32'h0, taken);
					end
				end
				4'h3: begin
					rdy_pattern = arg[15:0];
				end
				4'h4: begin
					bad_word[arg[7:0]] = 1'b1;
				end
				default: begin
					abort_run("unknown operation in the stimulus file");
				end
			endcase
		end
		$display("** PASS **");
		$finish;
	end

endmodule

//--- tests/fetch_frontend_assert.sv
/*
 * concurrent checks on the fetch bus and the CIR level,
 * bound into the fetch front end top level
 */

`timescale 1ns/10ps

module fetch_frontend_assert (
	input logic                         clk,
	input logic                         rst_n,
	input logic [fetch_pkg::W_ADDR-1:0] mem_addr,
	input logic                         mem_addr_vld,
	input logic                         mem_addr_rdy,
	input logic [1:0]                   cir_vld,
	input logic [1:0]                   cir_use
);

	// an address that was presented but not taken stays on the bus
	addr_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_addr_vld && !mem_addr_rdy |=> mem_addr_vld && $stable(mem_addr))
		else $error("fetch address changed while it was held");

	// the CIR holds two halfwords at most
	cir_level: assert property (@(posedge clk) disable iff (!rst_n) cir_vld <= 2'd2)
		else $error("cir_vld above two halfwords");

	// decode cannot take more than it was shown
	use_level: assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld)
		else $error("cir_use above cir_vld");

	// the first cycle out of reset issues no request
	reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !mem_addr_vld)
		else $error("fetch request in the first cycle after reset");

endmodule

bind fetch_frontend fetch_frontend_assert u_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.mem_addr     (mem_addr),
	.mem_addr_vld (mem_addr_vld),
	.mem_addr_rdy (mem_addr_rdy),
	.cir_vld      (cir_vld),
	.cir_use      (cir_use)
);

//--- hw/fetch_frontend.sv
/*
 * top level of the instruction fetch front end
 * fetch controller, prefetch queue, aligner and predecode
 */

`timescale 1ns/10ps

module fetch_frontend #(
	parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT,
	parameter logic [fetch_pkg::W_ADDR-1:0] RESET_VECTOR = fetch_pkg::RESET_VECTOR_DEFAULT
) (
	input  logic                        clk,
	input  logic                        rst_n,
	// memory bus, word-sized and word-aligned
	output logic [fetch_pkg::W_ADDR-1:0] mem_addr,
	output logic                        mem_addr_vld,
	input  logic                        mem_addr_rdy,
	input  logic [fetch_pkg::W_DATA-1:0] mem_data,
	input  logic                        mem_data_err,
	input  logic                        mem_data_vld,
	// jumps from the core
	input  logic [fetch_pkg::W_ADDR-1:0] jump_target,
	input  logic                        jump_target_vld,
	output logic                        jump_target_rdy,
	// decode side
	output logic [31:0]                 cir,
	output logic [1:0]                  cir_vld,
	output logic [1:0]                  cir_err,
	input  logic [1:0]                  cir_use,
	output logic [4:0]                  next_regs_rs1,
	output logic [4:0]                  next_regs_rs2
);

	logic                        jump_now;
	logic                        queue_push;
	logic                        queue_pop;
	logic                        queue_empty;
	logic                        queue_full;
	logic                        queue_almost_full;
	logic [fetch_pkg::W_DATA-1:0] queue_rdata;
	logic                        queue_rerr;
	logic                        cir_must_refill;
	logic                        fetch_data_vld;
	logic                        unaligned_jump_dph;
	fetch_pkg::instr_word_u      next_instr;

	fetch_ctrl #(
		.RESET_VECTOR (RESET_VECTOR),
		.FIFO_DEPTH   (FIFO_DEPTH)
	) u_ctrl (
		.clk                (clk),
		.rst_n              (rst_n),
		.jump_target        (jump_target),
		.jump_target_vld    (jump_target_vld),
		.jump_target_rdy    (jump_target_rdy),
		.jump_now           (jump_now),
		.mem_addr           (mem_addr),
		.mem_addr_vld       (mem_addr_vld),
		.mem_addr_rdy       (mem_addr_rdy),
		.mem_data_vld       (mem_data_vld),
		.queue_full         (queue_full),
		.queue_almost_full  (queue_almost_full),
		.queue_empty        (queue_empty),
		.queue_push         (queue_push),
		.queue_pop          (queue_pop),
		.cir_must_refill    (cir_must_refill),
		.fetch_data_vld     (fetch_data_vld),
		.unaligned_jump_dph (unaligned_jump_dph)
	);

	// the queue is emptied in the jump cycle itself
	prefetch_queue #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_data     (mem_data),
		.mem_data_err (mem_data_err),
		.push         (queue_push),
		.pop          (queue_pop),
		.flush        (jump_now),
		.rdata        (queue_rdata),
		.rerr         (queue_rerr),
		.empty        (queue_empty),
		.full         (queue_full),
		.almost_full  (queue_almost_full)
	);

	instr_align u_align (
		.clk                (clk),
		.rst_n              (rst_n),
		.mem_data           (mem_data),
		.mem_data_err       (mem_data_err),
		.queue_rdata        (queue_rdata),
		.queue_rerr         (queue_rerr),
		.queue_empty        (queue_empty),
		.fetch_data_vld     (fetch_data_vld),
		.unaligned_jump_dph (unaligned_jump_dph),
		.flush              (jump_now),
		.cir                (cir),
		.cir_vld            (cir_vld),
		.cir_err            (cir_err),
		.cir_use            (cir_use),
		.cir_must_refill    (cir_must_refill),
		.next_instr         (next_instr)
	);

	regnum_predecode u_predecode (
		.next_instr    (next_instr),
		.next_regs_rs1 (next_regs_rs1),
		.next_regs_rs2 (next_regs_rs2)
	);

endmodule

//--- hw/regnum_predecode.sv
/*
 * register number predecode for the instruction that
 * enters the CIR next, 32-bit and compressed formats
 */

`timescale 1ns/10ps

module regnum_predecode (
	input  fetch_pkg::instr_word_u next_instr,
	output logic [4:0]             next_regs_rs1,
	output logic [4:0]             next_regs_rs2
);

	logic [1:0] quadrant;
	logic [2:0] c_funct3;

	assign quadrant = next_instr.rvc.op;
	assign c_funct3 = next_instr.rvc.funct3;

	always_comb begin
		if (quadrant == 2'b11) begin
			// full-size instruction, fields at fixed places
			next_regs_rs1 = next_instr.rv32.rs1;
			next_regs_rs2 = next_instr.rv32.rs2;
		end else begin
			// most compressed forms name x8..x15 through 3-bit fields
			next_regs_rs1 = {2'b01, next_instr.rvc.rs1.prime};
			next_regs_rs2 = {2'b01, next_instr.rvc.rs2.prime};
			case (quadrant)
				2'b00: begin
					// c.addi4spn works off the stack pointer
					if (c_funct3 == 3'b000) begin
						next_regs_rs1 = 5'd2;
					end
				end
				2'b01: begin
					if (c_funct3 == 3'b011) begin
						// c.addi16sp
						next_regs_rs1 = 5'd2;
					end else if (c_funct3 == 3'b000) begin
						// c.addi reads its own full rd
						next_regs_rs1 = next_instr.rvc.rs1;
					end
				end
				default: begin
					// quadrant 2 uses the full 5-bit fields
					next_regs_rs2 = next_instr.rvc.rs2;
					if (c_funct3 == 3'b010 || c_funct3 == 3'b110) begin
						// c.lwsp and c.swsp
						next_regs_rs1 = 5'd2;
					end else begin
						next_regs_rs1 = next_instr.rvc.rs1;
					end
				end
			endcase
		end
	end

endmodule

//--- hw/instr_align.sv
/*
 * instruction assembly yard: three-halfword buffer made of
 * the upper halfword buffer and the CIR, its level and error bits,
 * shift-out of used halfwords and overlay of fetched words
 */

`timescale 1ns/10ps

module instr_align (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [fetch_pkg::W_DATA-1:0]   mem_data,
	input  logic                          mem_data_err,
	input  logic [fetch_pkg::W_DATA-1:0]   queue_rdata,
	input  logic                          queue_rerr,
	input  logic                          queue_empty,
	input  logic                          fetch_data_vld,
	input  logic                          unaligned_jump_dph,
	input  logic                          flush,
	output logic [31:0]                   cir,
	output logic [1:0]                    cir_vld,
	output logic [1:0]                    cir_err,
	input  logic [1:0]                    cir_use,
	output logic                          cir_must_refill,
	output fetch_pkg::instr_word_u        next_instr
);

	localparam int WB = fetch_pkg::W_BUNDLE;

	// buf_level counts valid halfwords in {hwbuf, cir}
	logic [1:0]                 buf_level;
	logic [1:0]                 buf_level_next;
	logic [1:0]                 level_after_use;
	logic [WB-1:0]              hwbuf;
	logic [2:0]                 buf_err;
	logic [fetch_pkg::W_DATA-1:0] fetch_data;
	logic                       fetch_err;
	logic [3*WB-1:0]            data_shifted;
	logic [3*WB-1:0]            data_plus_fetch;
	logic [2:0]                 err_shifted;
	logic [2:0]                 err_plus_fetch;
	logic                       overlay_blocked;

	// queue head when there is one, else the word on the bus
	assign fetch_data = queue_empty ? mem_data : queue_rdata;
	assign fetch_err  = queue_empty ? mem_data_err : queue_rerr;

	// ------------------------------
	// shift out what decode used
	// ------------------------------

	// slots that end up empty or overwritten get whatever is cheapest
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[WB +: WB], hwbuf};
			err_shifted  = buf_err >> 2;
		end else if (cir_use[0]) begin
			data_shifted = {hwbuf, hwbuf, cir[WB +: WB]};
			err_shifted  = buf_err >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted  = buf_err;
		end
	end

	// saturate at zero so a stray cir_use can never wrap the level
	assign level_after_use = (cir_use >= buf_level) ? 2'd0 : buf_level - cir_use;

	// ------------------------------
	// overlay fresh fetch data
	// ------------------------------

	// two halfwords still waiting leave no room for a whole word
	assign overlay_blocked = level_after_use[1] && !unaligned_jump_dph;
	assign cir_must_refill = !level_after_use[1];

	always_comb begin
		if (overlay_blocked) begin
			data_plus_fetch = data_shifted;
			err_plus_fetch  = err_shifted;
		end else if (unaligned_jump_dph) begin
			// the target sits in the upper half of its word
			data_plus_fetch = {data_shifted[WB +: 2*WB], fetch_data[WB +: WB]};
			err_plus_fetch  = {err_shifted[2:1], fetch_err};
		end else if (level_after_use[0]) begin
			// one halfword left over, the new word goes on top of it
			data_plus_fetch = {fetch_data, data_shifted[0 +: WB]};
			err_plus_fetch  = {{2{fetch_err}}, err_shifted[0]};
		end else begin
			data_plus_fetch = {data_shifted[2*WB +: WB], fetch_data};
			err_plus_fetch  = {err_shifted[2], {2{fetch_err}}};
		end
	end

	// a jump empties the yard, the first word after an unaligned jump adds one
	always_comb begin
		if (flush) begin
			buf_level_next = 2'd0;
		end else if (fetch_data_vld && unaligned_jump_dph) begin
			buf_level_next = 2'd1;
		end else if (cir_must_refill && fetch_data_vld) begin
			buf_level_next = level_after_use + 2'd2;
		end else begin
			buf_level_next = level_after_use;
		end
	end

	// ------------------------------
	// registers
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld   <= 2'd0;
			buf_err   <= 3'd0;
		end else begin
			buf_level <= buf_level_next;
			// decode never sees more than the CIR itself
			cir_vld   <= (buf_level_next > 2'd2) ? 2'd2 : buf_level_next;
			buf_err   <= err_plus_fetch;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_plus_fetch;
	end

	assign cir_err    = buf_err[1:0];
	// the word that will sit in the CIR on the next edge
	assign next_instr = data_plus_fetch[31:0];

endmodule

//--- hw/prefetch_queue.sv
/*
 * prefetch queue: shifting queue of fetched words,
 * each with its bus error bit, head always in entry 0
 */

`timescale 1ns/10ps

module prefetch_queue #(
	parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [fetch_pkg::W_DATA-1:0] mem_data,
	input  logic                        mem_data_err,
	input  logic                        push,
	input  logic                        pop,
	input  logic                        flush,
	output logic [fetch_pkg::W_DATA-1:0] rdata,
	output logic                        rerr,
	output logic                        empty,
	output logic                        full,
	output logic                        almost_full
);

	// second-to-last entry, clamped for a single-entry queue
	localparam int AF_IDX = (FIFO_DEPTH > 1) ? FIFO_DEPTH - 2 : 0;

	logic [fetch_pkg::W_DATA-1:0] mem [0:FIFO_DEPTH-1];
	logic [FIFO_DEPTH-1:0]       err;
	logic [FIFO_DEPTH-1:0]       valid;
	logic [FIFO_DEPTH-1:0]       valid_next;

	assign rdata       = mem[0];
	assign rerr        = err[0];
	assign empty       = !valid[0];
	assign full        = valid[FIFO_DEPTH-1];
	assign almost_full = (FIFO_DEPTH == 1) || (!valid[FIFO_DEPTH-1] && valid[AF_IDX]);

	// valid bits fill from the bottom, a pop drops the head, a push adds one above
	always_comb begin
		valid_next = valid;
		if (pop) begin
			valid_next = valid_next >> 1;
		end
		if (push) begin
			valid_next = (valid_next << 1) | FIFO_DEPTH'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (flush) begin
			// words of the old stream are simply forgotten
			valid <= '0;
		end else begin
			valid <= valid_next;
		end
	end

	// each entry takes the next valid one, or the bus word past the last valid one
	always_ff @(posedge clk) begin
		for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
			if (pop || (push && !valid[i])) begin
				mem[i] <= valid[i+1] ? mem[i+1] : mem_data;
				err[i] <= valid[i+1] ? err[i+1] : mem_data_err;
			end
		end
		// nothing sits above the top entry, so it can only take the bus word
		if (pop || (push && !valid[FIFO_DEPTH-1])) begin
			mem[FIFO_DEPTH-1] <= mem_data;
			err[FIFO_DEPTH-1] <= mem_data_err;
		end
	end

endmodule

//--- hw/fetch_ctrl.sv
/*
 * fetch controller: address-phase request generation,
 * fetch address counter, in-flight and flush counters,
 * queue push and pop strobes, unaligned jump flags
 */

`timescale 1ns/10ps

module fetch_ctrl #(
	parameter logic [fetch_pkg::W_ADDR-1:0] RESET_VECTOR = fetch_pkg::RESET_VECTOR_DEFAULT,
	parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [fetch_pkg::W_ADDR-1:0] jump_target,
	input  logic                        jump_target_vld,
	output logic                        jump_target_rdy,
	output logic                        jump_now,
	output logic [fetch_pkg::W_ADDR-1:0] mem_addr,
	output logic                        mem_addr_vld,
	input  logic                        mem_addr_rdy,
	input  logic                        mem_data_vld,
	input  logic                        queue_full,
	input  logic                        queue_almost_full,
	input  logic                        queue_empty,
	output logic                        queue_push,
	output logic                        queue_pop,
	input  logic                        cir_must_refill,
	output logic                        fetch_data_vld,
	output logic                        unaligned_jump_dph
);

	// a single-entry queue cannot absorb two words in flight
	localparam int MAX_PENDING = (FIFO_DEPTH > 1) ? 2 : 1;

	logic                        mem_addr_hold;
	logic [1:0]                  pending_fetches;
	logic [1:0]                  flush_cnt;
	logic [fetch_pkg::W_ADDR-1:0] fetch_addr;
	logic                        unaligned_jump_aph;
	logic                        reset_holdoff;
	logic                        addr_req;
	logic                        addr_accept;
	logic                        fetch_stall;
	logic                        flushing;
	logic                        unaligned_jump_now;

	// ------------------------------
	// bus state
	// ------------------------------

	assign addr_accept = mem_addr_vld && mem_addr_rdy;
	assign flushing    = |flush_cnt;

	// an address that was presented but not taken must stay on the bus,
	// so jumps wait until the hold is over
	assign jump_target_rdy    = !mem_addr_hold;
	assign jump_now           = jump_target_vld && jump_target_rdy;
	assign unaligned_jump_now = jump_now && jump_target[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff   <= 1'b1;
			mem_addr_hold   <= 1'b0;
			pending_fetches <= 2'd0;
			flush_cnt       <= 2'd0;
		end else begin
			reset_holdoff   <= 1'b0;
			mem_addr_hold   <= mem_addr_vld && !mem_addr_rdy;
			// only accepted addresses count as in flight
			pending_fetches <= pending_fetches + 2'(addr_accept) - 2'(mem_data_vld);
			// everything still in flight at a jump belongs to the old stream
			if (jump_now) begin
				flush_cnt <= pending_fetches - 2'(mem_data_vld);
			end else if (flushing && mem_data_vld) begin
				flush_cnt <= flush_cnt - 2'd1;
			end
		end
	end

	// the fetch address runs ahead of the pc in whole words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= RESET_VECTOR;
		end else if (jump_now) begin
			// step past the target at once if the bus took it in the jump cycle
			fetch_addr <= {jump_target[fetch_pkg::W_ADDR-1:2] + 30'(addr_accept), 2'b00};
		end else if (addr_accept) begin
			fetch_addr <= fetch_addr + fetch_pkg::W_ADDR'(4);
		end
	end

	// ------------------------------
	// unaligned jumps
	// ------------------------------

	// aph marks a halfword target whose word address is still waiting on the bus,
	// dph marks that its first data word must go in from the upper halfword
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unaligned_jump_aph <= 1'b0;
			unaligned_jump_dph <= 1'b0;
		end else begin
			if (addr_accept) begin
				unaligned_jump_aph <= 1'b0;
			end
			// target data cannot arrive before its address was taken
			if (fetch_data_vld && !unaligned_jump_aph) begin
				unaligned_jump_dph <= 1'b0;
			end
			// a new jump overrides whatever the flags said
			if (jump_now) begin
				unaligned_jump_aph <= unaligned_jump_now && !addr_accept;
				unaligned_jump_dph <= unaligned_jump_now;
			end
		end
	end

	// ------------------------------
	// address-phase request
	// ------------------------------

	// the pending count is the registered one to keep the bus ready out of this path
	assign fetch_stall = queue_full
		|| (queue_almost_full && |pending_fetches)
		|| (pending_fetches >= 2'(MAX_PENDING));

	always_comb begin
		addr_req = 1'b1;
		mem_addr = '0;
		if (mem_addr_hold) begin
			mem_addr = fetch_addr;
		end else if (jump_target_vld) begin
			// accesses are always whole aligned words
			mem_addr = {jump_target[fetch_pkg::W_ADDR-1:2], 2'b00};
		end else if (!fetch_stall) begin
			mem_addr = fetch_addr;
		end else begin
			addr_req = 1'b0;
		end
	end

	assign mem_addr_vld = addr_req && !reset_holdoff;

	// ------------------------------
	// data phase
	// ------------------------------

	// the aligner takes the queue head, or the bus word when the queue is empty
	assign fetch_data_vld = !queue_empty || (mem_data_vld && !flushing);
	assign queue_pop      = cir_must_refill && !queue_empty;
	// a word forwarded straight to the aligner must not be queued as well
	assign queue_push     = mem_data_vld && !flushing && !(cir_must_refill && queue_empty);

endmodule

//--- hw/fetch_pkg.sv
/*
 * shared definitions of the instruction fetch front end
 * address, bus word and halfword widths, parameter defaults,
 * and the 32-bit instruction word union with rv32 and rvc views
 */

package fetch_pkg;

	// ------------------------------
	// widths
	// ------------------------------

	localparam int W_ADDR   = 32;
	localparam int W_DATA   = 32;
	// decode consumes the CIR in halfword bundles
	localparam int W_BUNDLE = W_DATA / 2;

	// defaults for the top level parameters
	localparam int                FIFO_DEPTH_DEFAULT   = 2;
	localparam logic [W_ADDR-1:0] RESET_VECTOR_DEFAULT = 32'h0000_0000;

	// ------------------------------
	// instruction word views
	// ------------------------------

	// 32-bit base encoding, register fields at fixed positions
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv32_fields_t;

	// a compressed register field is either the full 5-bit number
	// or, in the popular-register forms, only its low 3 bits (x8..x15)
	typedef struct packed {
		logic [1:0] hi;
		logic [2:0] prime;
	} rvc_reg_t;

	// 16-bit encoding in the low halfword, the upper halfword is not part of it
	typedef struct packed {
		logic [15:0] unused;
		logic [2:0]  funct3;
		logic        b12;
		rvc_reg_t    rs1;
		rvc_reg_t    rs2;
		logic [1:0]  op;
	} rvc_fields_t;

	typedef union packed {
		rv32_fields_t rv32;
		rvc_fields_t  rvc;
	} instr_word_u;

endpackage
